//--- src/fc_pkg.sv
package fc_pkg;

    // widths shared by feeder, lanes and activation stage
    localparam int NODE_W    = 7;   // output node count / node index
    localparam int TILE_W    = 4;   // tile count
    localparam int ACC_W     = 32;  // partial sum word
    localparam int DATA_W    = 8;   // activation, weight and result
    localparam int ACC_SHIFT = 3;   // arithmetic shift before saturation

    typedef logic signed [ACC_W-1:0] acc_word_t;

    // layer configuration, sampled on the first beat of a layer
    typedef struct packed {
        logic [NODE_W-1:0] out_node_num;  // 2 or more
        logic [TILE_W-1:0] tile_num;      // 1 or more
    } fc_cfg_t;

    // one lane result toward the activation stage
    typedef struct packed {
        logic                     valid;
        logic                     last;
        logic signed [DATA_W-1:0] result;
    } lane_out_t;

endpackage

//--- src/simple_dual_one_clock.sv
module simple_dual_one_clock #(
    parameter int SRAM_DEPTH = 128,
    parameter int DATA_WIDTH = 32
) (
    input  logic                          clk,
    input  logic                          wea_i,
    input  logic                          enb_i,
    input  logic [$clog2(SRAM_DEPTH)-1:0] addra_i,
    input  logic [$clog2(SRAM_DEPTH)-1:0] addrb_i,
    input  logic [DATA_WIDTH-1:0]         dia_i,
    output logic [DATA_WIDTH-1:0]         dob_o
);

    logic [DATA_WIDTH-1:0] mem [SRAM_DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (wea_i) mem[addra_i] <= dia_i;
    end

    // registered read, same-address collision returns the old word
    always_ff @(posedge clk) begin
        if (enb_i) dob_o <= mem[addrb_i];
    end

endmodule

//--- src/fc_feeder.sv
module fc_feeder #(
    parameter int NUM_LANES = 4
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    beat_valid_i,
    input  logic signed [fc_pkg::DATA_W-1:0]        act_i,
    input  logic [NUM_LANES*fc_pkg::DATA_W-1:0]     weights_i,
    input  fc_pkg::fc_cfg_t                         cfg_i,
    output logic                                    pvalid_o,
    output fc_pkg::fc_cfg_t                         cfg_o,
    output fc_pkg::acc_word_t [NUM_LANES-1:0]       psum_o
);

    localparam int BEAT_W = fc_pkg::NODE_W + fc_pkg::TILE_W;

    logic [BEAT_W-1:0] beat_cnt;     // position inside the current layer
    logic [BEAT_W-1:0] beats_total;
    fc_pkg::fc_cfg_t   cfg_q;

    // nodes times tiles, fits in BEAT_W bits
    assign beats_total = cfg_q.out_node_num * cfg_q.tile_num;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            cfg_q    <= '0;
            pvalid_o <= 1'b0;
        end else begin
            pvalid_o <= beat_valid_i;
            if (beat_valid_i) begin
                if (beat_cnt == '0) begin
                    // first beat of a layer
                    cfg_q    <= cfg_i;
                    beat_cnt <= BEAT_W'(1);
                end else if (beat_cnt == beats_total - 1'b1) begin
                    beat_cnt <= '0;  // layer complete
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
        end
    end

    // one signed product per lane, sign extended to the accumulator word
    always_ff @(posedge clk) begin
        if (beat_valid_i) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                psum_o[l] <= fc_pkg::acc_word_t'(
                    act_i * $signed(weights_i[l*fc_pkg::DATA_W +: fc_pkg::DATA_W]));
            end
        end
    end

    assign cfg_o = cfg_q;

endmodule

//--- src/fc_accumulator.sv
module fc_accumulator (
    input  logic               clk,
    input  logic               rst_n,
    input  fc_pkg::acc_word_t  psum_i,
    input  logic               pvalid_i,
    input  fc_pkg::fc_cfg_t    cfg_i,
    output fc_pkg::lane_out_t  lane_o
);

    localparam int NODE_W = fc_pkg::NODE_W;
    localparam int TILE_W = fc_pkg::TILE_W;
    localparam int DATA_W = fc_pkg::DATA_W;

    localparam fc_pkg::acc_word_t SAT_MAX = (2 ** (DATA_W - 1)) - 1;
    localparam fc_pkg::acc_word_t SAT_MIN = -(2 ** (DATA_W - 1));

    typedef enum logic [2:0] {
        S_INIT,
        S_ACC,
        S_WRITE,
        S_OUT,
        S_LAST_OUT
    } state_t;

    state_t state, state_n;

    logic [NODE_W-1:0] node_cnt, node_cnt_n;  // node of next beat, read pointer when out
    logic [TILE_W-1:0] tile_cnt, tile_cnt_n;
    logic [NODE_W-1:0] last_node;
    logic [TILE_W-1:0] last_tile;

    logic              rd_en;
    logic [NODE_W-1:0] rd_addr;
    logic [NODE_W-1:0] wr_addr;   // node being written back
    logic              pvalid_d;
    logic              first_d;   // product belongs to tile 0

    fc_pkg::acc_word_t psum_q;
    fc_pkg::acc_word_t ram_q;
    fc_pkg::acc_word_t acc_sum;
    fc_pkg::acc_word_t shifted;
    logic signed [DATA_W-1:0] sat;

    logic out_valid;
    logic out_last;

    assign last_node = cfg_i.out_node_num - 1'b1;
    assign last_tile = cfg_i.tile_num - 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= S_INIT;
            node_cnt <= '0;
            tile_cnt <= '0;
            pvalid_d <= 1'b0;
        end else begin
            state    <= state_n;
            node_cnt <= node_cnt_n;
            tile_cnt <= tile_cnt_n;
            pvalid_d <= pvalid_i;
        end
    end

    // write-back operands, one cycle behind the read
    always_ff @(posedge clk) begin
        if (pvalid_i) begin
            psum_q  <= psum_i;
            wr_addr <= node_cnt;
            first_d <= (tile_cnt == '0);
        end
    end

    always_comb begin
        state_n    = state;
        node_cnt_n = node_cnt;
        tile_cnt_n = tile_cnt;
        rd_en      = 1'b0;
        rd_addr    = node_cnt;
        out_valid  = 1'b0;
        out_last   = 1'b0;

        case (state)
            S_INIT, S_ACC: begin
                if (pvalid_i) begin
                    rd_en   = 1'b1;  // fetch partial sum of this node
                    state_n = S_ACC;
                    if (node_cnt == last_node) begin
                        node_cnt_n = '0;
                        if (tile_cnt == last_tile) begin
                            tile_cnt_n = '0;
                            state_n    = S_WRITE;
                        end else begin
                            tile_cnt_n = tile_cnt + 1'b1;
                        end
                    end else begin
                        node_cnt_n = node_cnt + 1'b1;
                    end
                end
            end
            S_WRITE: begin
                // final write-back lands here, node 0 read starts
                rd_en      = 1'b1;
                rd_addr    = '0;
                node_cnt_n = NODE_W'(1);
                state_n    = S_OUT;
            end
            S_OUT: begin
                out_valid = 1'b1;
                rd_en     = 1'b1;
                if (node_cnt == last_node) begin
                    node_cnt_n = '0;
                    state_n    = S_LAST_OUT;
                end else begin
                    node_cnt_n = node_cnt + 1'b1;
                end
            end
            S_LAST_OUT: begin
                out_valid = 1'b1;
                out_last  = 1'b1;
                state_n   = S_INIT;
            end
            default: state_n = S_INIT;
        endcase
    end

    // first tile starts from zero instead of stale RAM content
    assign acc_sum = psum_q + (first_d ? fc_pkg::acc_word_t'(0) : ram_q);

    // shift and clamp to int8
    always_comb begin
        shifted = ram_q >>> fc_pkg::ACC_SHIFT;
        if (shifted > SAT_MAX) begin
            sat = SAT_MAX[DATA_W-1:0];
        end else if (shifted < SAT_MIN) begin
            sat = SAT_MIN[DATA_W-1:0];
        end else begin
            sat = shifted[DATA_W-1:0];
        end
    end

    simple_dual_one_clock #(
        .SRAM_DEPTH (2 ** NODE_W),
        .DATA_WIDTH (fc_pkg::ACC_W)
    ) u_acc_ram (
        .clk     (clk),
        .wea_i   (pvalid_d),
        .enb_i   (rd_en),
        .addra_i (wr_addr),
        .addrb_i (rd_addr),
        .dia_i   (acc_sum),
        .dob_o   (ram_q)
    );

    assign lane_o.valid  = out_valid;
    assign lane_o.last   = out_last;
    assign lane_o.result = sat;

endmodule

//--- src/fc_activation.sv
module fc_activation #(
    parameter int NUM_LANES = 4
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  fc_pkg::lane_out_t [NUM_LANES-1:0]    lane_i,
    input  logic                                 relu_en_i,
    output logic                                 fc_valid_o,
    output logic                                 fc_last_o,
    output logic [NUM_LANES*fc_pkg::DATA_W-1:0]  fc_result_o
);

    localparam int DATA_W = fc_pkg::DATA_W;

    logic [NUM_LANES*DATA_W-1:0] act_vec;

    // optional relu per lane
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            if (relu_en_i && lane_i[l].result < 0) begin
                act_vec[l*DATA_W +: DATA_W] = '0;
            end else begin
                act_vec[l*DATA_W +: DATA_W] = lane_i[l].result;
            end
        end
    end

    // lanes run in lockstep, lane 0 carries the handshake
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fc_valid_o <= 1'b0;
            fc_last_o  <= 1'b0;
        end else begin
            fc_valid_o <= lane_i[0].valid;
            fc_last_o  <= lane_i[0].last;
        end
    end

    always_ff @(posedge clk) begin
        if (lane_i[0].valid) fc_result_o <= act_vec;
    end

endmodule

//--- src/fc_top.sv
module fc_top #(
    parameter int NUM_LANES = 4
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 beat_valid_i,
    input  logic signed [fc_pkg::DATA_W-1:0]     act_i,
    input  logic [NUM_LANES*fc_pkg::DATA_W-1:0]  weights_i,
    input  fc_pkg::fc_cfg_t                      cfg_i,
    input  logic                                 relu_en_i,
    output logic                                 fc_valid_o,
    output logic                                 fc_last_o,
    output logic [NUM_LANES*fc_pkg::DATA_W-1:0]  fc_result_o
);

    logic                                pvalid;
    fc_pkg::fc_cfg_t                     cfg;
    fc_pkg::acc_word_t [NUM_LANES-1:0]   psum;
    fc_pkg::lane_out_t [NUM_LANES-1:0]   lane_out;

    fc_feeder #(
        .NUM_LANES (NUM_LANES)
    ) u_feeder (
        .clk          (clk),
        .rst_n        (rst_n),
        .beat_valid_i (beat_valid_i),
        .act_i        (act_i),
        .weights_i    (weights_i),
        .cfg_i        (cfg_i),
        .pvalid_o     (pvalid),
        .cfg_o        (cfg),
        .psum_o       (psum)
    );

    // one accumulator per output lane
    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        fc_accumulator u_acc (
            .clk      (clk),
            .rst_n    (rst_n),
            .psum_i   (psum[l]),
            .pvalid_i (pvalid),
            .cfg_i    (cfg),
            .lane_o   (lane_out[l])
        );
    end

    fc_activation #(
        .NUM_LANES (NUM_LANES)
    ) u_activation (
        .clk         (clk),
        .rst_n       (rst_n),
        .lane_i      (lane_out),
        .relu_en_i   (relu_en_i),
        .fc_valid_o  (fc_valid_o),
        .fc_last_o   (fc_last_o),
        .fc_result_o (fc_result_o)
    );

endmodule

//--- testbench/fc_top_properties.sv
module fc_top_properties #(
    parameter int NUM_LANES = 4
) (
    input logic                                clk,
    input logic                                rst_n,
    input logic                                valid_i,
    input logic                                last_i,
    input logic [NUM_LANES*fc_pkg::DATA_W-1:0] result_i
);

    // last only ever marks a valid output
    last_with_valid: assert property (
        @(posedge clk) disable iff (!rst_n) last_i |-> valid_i
    ) else $error("fc_last_o high without fc_valid_o");

    // synchronous reset, so outputs are clear from the edge after rst_n is seen low
    quiet_in_reset: assert property (
        @(posedge clk) !rst_n |=> (!valid_i && !last_i)
    ) else $error("output handshake active during reset");

    result_known: assert property (
        @(posedge clk) disable iff (!rst_n) valid_i |-> !$isunknown(result_i)
    ) else $error("fc_result_o has unknown bits while valid");

endmodule

bind fc_top fc_top_properties #(
    .NUM_LANES (NUM_LANES)
) u_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .valid_i  (fc_valid_o),
    .last_i   (fc_last_o),
    .result_i (fc_result_o)
);

//--- testbench/tb_fc_top.sv
module tb_fc_top;

    localparam int NUM_LANES = 4;
    localparam int DATA_W    = fc_pkg::DATA_W;
    localparam int MAX_TILES = 16;
    localparam int MAX_NODES = 128;
    localparam int TIMEOUT   = 60;  // cycles allowed per output
    localparam int NUM_CASES = 7;

    localparam logic [1:0] MODE_RAND = 2'd0;
    localparam logic [1:0] MODE_POS  = 2'd1;  // all operands +127
    localparam logic [1:0] MODE_NEG  = 2'd2;  // act +127, weights -128

    typedef struct packed {
        fc_pkg::fc_cfg_t cfg;
        logic            relu;
        logic [1:0]      mode;
    } layer_t;

    // nodes, tiles, relu, data mode; run back to back
    layer_t layer_table [NUM_CASES] = '{
        {7'd8,  4'd1, 1'b0, MODE_RAND},
        {7'd6,  4'd5, 1'b0, MODE_RAND},
        {7'd4,  4'd3, 1'b0, MODE_POS},
        {7'd4,  4'd3, 1'b0, MODE_NEG},
        {7'd10, 4'd2, 1'b1, MODE_RAND},
        {7'd2,  4'd1, 1'b0, MODE_RAND},
        {7'd20, 4'd3, 1'b1, MODE_RAND}
    };
    string layer_name [NUM_CASES] = '{"single_tile", "multi_tile", "sat_pos", "sat_neg",
                                      "relu_rand", "b2b_small", "b2b_large"};

    logic                        clk;
    logic                        rst_n;
    logic                        beat_valid;
    logic signed [DATA_W-1:0]    act;
    logic [NUM_LANES*DATA_W-1:0] weights;
    fc_pkg::fc_cfg_t             cfg;
    logic                        relu_en;
    logic                        fc_valid;
    logic                        fc_last;
    logic [NUM_LANES*DATA_W-1:0] fc_result;

    logic [15:0]              lfsr_state;
    logic signed [DATA_W-1:0] act_mem [MAX_TILES][MAX_NODES];
    logic signed [DATA_W-1:0] w_mem [MAX_TILES][MAX_NODES][NUM_LANES];
    int                       expected [MAX_NODES][NUM_LANES];

    fc_top #(
        .NUM_LANES (NUM_LANES)
    ) u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .beat_valid_i (beat_valid),
        .act_i        (act),
        .weights_i    (weights),
        .cfg_i        (cfg),
        .relu_en_i    (relu_en),
        .fc_valid_o   (fc_valid),
        .fc_last_o    (fc_last),
        .fc_result_o  (fc_result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // taps 16 14 13 11
    endfunction

    task automatic take_bits(input int n, output logic [7:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits       = {bits[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_value(input string name, input logic signed [31:0] exp_val,
                               input logic signed [31:0] act_val);
        if (exp_val !== act_val) begin
            $display("Mismatch %s: expected %0d actual %0d", name, exp_val, act_val);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    // fills operands and derives expected results from the result rule
    task automatic prepare_layer(input layer_t lt);
        logic [7:0] b;
        int         sum;
        for (int t = 0; t < int'(lt.cfg.tile_num); t++) begin
            for (int n = 0; n < int'(lt.cfg.out_node_num); n++) begin
                if (lt.mode == MODE_RAND) begin
                    take_bits(4, b);
                    act_mem[t][n] = {{4{b[3]}}, b[3:0]};  // small signed act
                end else begin
                    act_mem[t][n] = 8'sd127;
                end
                for (int c = 0; c < NUM_LANES; c++) begin
                    if (lt.mode == MODE_RAND) begin
                        take_bits(8, b);
                        w_mem[t][n][c] = b;
                    end else if (lt.mode == MODE_POS) begin
                        w_mem[t][n][c] = 8'sd127;
                    end else begin
                        w_mem[t][n][c] = 8'h80;
                    end
                end
            end
        end
        for (int n = 0; n < int'(lt.cfg.out_node_num); n++) begin
            for (int c = 0; c < NUM_LANES; c++) begin
                sum = 0;
                for (int t = 0; t < int'(lt.cfg.tile_num); t++) begin
                    sum += int'(act_mem[t][n]) * int'(w_mem[t][n][c]);
                end
                sum = sum >>> 3;
                if (sum > 127) sum = 127;
                else if (sum < -128) sum = -128;
                if (lt.relu && sum < 0) sum = 0;
                expected[n][c] = sum;
            end
        end
    endtask

    // tiles outer, nodes inner, idle cycle after every third beat
    task automatic drive_layer(input layer_t lt);
        int beat;
        beat = 0;
        for (int t = 0; t < int'(lt.cfg.tile_num); t++) begin
            for (int n = 0; n < int'(lt.cfg.out_node_num); n++) begin
                @(posedge clk);
                #10;
                beat_valid = 1'b1;
                act        = act_mem[t][n];
                cfg        = lt.cfg;
                relu_en    = lt.relu;
                for (int c = 0; c < NUM_LANES; c++) begin
                    weights[c*DATA_W +: DATA_W] = w_mem[t][n][c];
                end
                beat++;
                if (beat % 3 == 0) begin
                    @(posedge clk);
                    #10;
                    beat_valid = 1'b0;
                end
            end
        end
        @(posedge clk);
        #10;
        beat_valid = 1'b0;
    endtask

    task automatic wait_valid(input string what, output int cycles);
        cycles = 0;
        @(negedge clk);
        while (!fc_valid && cycles < TIMEOUT) begin
            cycles++;
            @(negedge clk);
        end
        if (!fc_valid) begin
            $display("Timeout: %s never arrived on fc_valid_o", what);
            $display("TEST RESULT: FAIL");
            $fatal(1, "output timeout");
        end
    endtask

    task automatic collect_layer(input string name, input layer_t lt);
        int gap;
        int last_n;
        last_n = int'(lt.cfg.out_node_num) - 1;
        for (int n = 0; n <= last_n; n++) begin
            wait_valid($sformatf("%s output %0d", name, n), gap);
            if (n > 0) check_value($sformatf("%s gap before node %0d", name, n), 0, gap);
            check_value($sformatf("%s last of node %0d", name, n), n == last_n, fc_last);
            for (int c = 0; c < NUM_LANES; c++) begin
                check_value($sformatf("%s node %0d lane %0d", name, n, c), expected[n][c],
                            $signed(fc_result[c*DATA_W +: DATA_W]));
            end
        end
        @(negedge clk);
        check_value($sformatf("%s valid after last", name), 0, fc_valid);
    endtask

    initial begin
        rst_n      = 1'b0;
        beat_valid = 1'b0;
        act        = '0;
        weights    = '0;
        cfg        = '0;
        relu_en    = 1'b0;
        lfsr_state = 16'd3304;
        repeat (4) @(posedge clk);
        #10;
        rst_n = 1'b1;
        for (int i = 0; i < NUM_CASES; i++) begin
            prepare_layer(layer_table[i]);
            drive_layer(layer_table[i]);
            collect_layer(layer_name[i], layer_table[i]);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- all.f
src/fc_pkg.sv
src/simple_dual_one_clock.sv
src/fc_feeder.sv
src/fc_accumulator.sv
src/fc_activation.sv
src/fc_top.sv
testbench/fc_top_properties.sv
testbench/tb_fc_top.sv

//--- run.sh
#!/usr/bin/env bash
# build with Verilator and run; success only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_fc_top -f all.f &&
./obj_dir/Vtb_fc_top | tee /dev/stderr | grep -q "TEST RESULT: PASS" &&
echo "simulation ok" ||
{ echo "simulation failed"; exit 1; }
